//--- hdl/fetch_defs.svh
// sizing and timing constants for the instruction fetch subsystem
// included by the package and by every RTL block that sizes arrays or counters
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// cache geometry, one 32-bit word per frame
`define ICACHE_FRAMES 16
`define IDX_BITS      4     // index is addr[5:2]
`define TAG_LSB       6     // tag is addr[31:6]

// instruction RAM
`define IMEM_WORDS    256
`define IMEM_ABITS    8     // word address is addr[9:2]

// wait cycles before iload is valid, 0 is legal too
`define IMEM_WAIT     3

`endif

//--- hdl/fetch_pkg.sv
// shared types for the fetch subsystem
// widths follow the macros in the defs header, used by scoped reference only
`include "fetch_defs.svh"

package fetch_pkg;

    // full instruction word, also a byte address
    typedef logic [31:0] word_t;

    // address fields seen by the cache
    typedef logic [31-`TAG_LSB:0] tag_t;   // upper address bits
    typedef logic [`IDX_BITS-1:0] idx_t;   // frame select

    // word address into the instruction RAM
    typedef logic [`IMEM_ABITS-1:0] imem_addr_t;

    // miss handling FSM of the cache
    typedef enum logic [1:0]
    {
        IDLE,       // waiting for a request
        COMPARE,    // tag check, decide on a fill
        ALLOCATE    // memory read in flight
    } icache_state_t;

endpackage

//--- hdl/icache.sv
// direct-mapped instruction cache of one-word frames
// hits come back in the same cycle as imemREN; a miss goes through COMPARE
// and ALLOCATE and fills one frame from imem_ctrl when iwait drops
`timescale 1ns/1ps
`include "fetch_defs.svh"

module icache (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             imemREN,   // fetch request level from datapath
    input  logic             halt,
    input  logic             iwait,     // memory still busy
    input  fetch_pkg::word_t iload,     // memory read data
    input  fetch_pkg::word_t imemaddr,  // fetch byte address, held until ihit
    output logic             ihit,
    output fetch_pkg::word_t imemload,
    output logic             iREN,      // memory read level, ALLOCATE only
    output fetch_pkg::word_t iaddr
);

    fetch_pkg::icache_state_t state;
    fetch_pkg::icache_state_t next_state;

    // address fields
    fetch_pkg::tag_t addr_tag;
    fetch_pkg::idx_t addr_idx;

    // frame storage
    logic [`ICACHE_FRAMES-1:0] valid;           // cleared by reset
    fetch_pkg::tag_t           tags [`ICACHE_FRAMES];
    fetch_pkg::word_t          data [`ICACHE_FRAMES];

    logic tag_match;   // addressed frame holds this address
    logic fill;        // memory word arrives this cycle

    assign addr_tag = imemaddr[31:`TAG_LSB];
    assign addr_idx = imemaddr[`TAG_LSB-1:2];   // word offset bits dropped

    assign tag_match = valid[addr_idx] && (tags[addr_idx] == addr_tag);

    // hit path is purely combinational, independent of the FSM state
    assign ihit     = imemREN && !halt && tag_match;
    assign imemload = ihit ? data[addr_idx] : '0;

    // frame written only once memory data is final
    assign fill = (state == fetch_pkg::ALLOCATE) && !iwait;

    // valid bits
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            valid <= '0;
        end
        else if (fill)
        begin
            valid[addr_idx] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge CLK)
    begin
        if (fill)
        begin
            tags[addr_idx] <= addr_tag;
            data[addr_idx] <= iload;
        end
    end

    // state register
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            state <= fetch_pkg::IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // next state
    always_comb
    begin
        next_state = state;
        case (state)
            fetch_pkg::IDLE:
            begin
                if (imemREN && !halt)
                begin
                    next_state = fetch_pkg::COMPARE;
                end
            end
            fetch_pkg::COMPARE:
            begin
                // no new miss while halted or without a request
                if (imemREN && !halt && !tag_match)
                begin
                    next_state = fetch_pkg::ALLOCATE;
                end
                else
                begin
                    next_state = fetch_pkg::IDLE;
                end
            end
            fetch_pkg::ALLOCATE:
            begin
                if (!iwait)
                begin
                    next_state = fetch_pkg::COMPARE;   // hit shows next cycle
                end
            end
            default:
            begin
                next_state = fetch_pkg::IDLE;
            end
        endcase
    end

    // memory side outputs
    always_comb
    begin
        iREN  = 1'b0;
        iaddr = '0;
        if (state == fetch_pkg::ALLOCATE)
        begin
            iREN  = 1'b1;       // held through the fill even if halt rises
            iaddr = imemaddr;   // steady, datapath waits for ihit
        end
    end

endmodule

//--- hdl/imem_ctrl.sv
// instruction memory controller with a program-load write port
// a read holds iwait high for IMEM_WAIT cycles, then returns iload for one cycle
// with iwait low; the count restarts on iREN rising or a new iaddr
`timescale 1ns/1ps
`include "fetch_defs.svh"

module imem_ctrl (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   iREN,       // read level from the cache
    input  fetch_pkg::word_t       iaddr,      // byte address
    input  logic                   load_en,    // program load write strobe
    input  fetch_pkg::imem_addr_t  load_addr,  // word address
    input  fetch_pkg::word_t       load_data,
    output logic                   iwait,
    output fetch_pkg::word_t       iload
);

    // word RAM, contents survive reset
    fetch_pkg::word_t ram [`IMEM_WORDS];

    fetch_pkg::imem_addr_t word_addr;
    fetch_pkg::word_t      prev_addr;   // iaddr of last cycle
    logic                  prev_ren;    // iREN of last cycle
    logic [7:0]            wait_cnt;    // wait cycles already spent
    logic [7:0]            cur_cnt;
    logic                  restart;

    assign word_addr = iaddr[`IMEM_ABITS+1:2];

    // program load
    always_ff @(posedge CLK)
    begin
        if (load_en)
        begin
            ram[load_addr] <= load_data;
        end
    end

    // read data, only sampled when iwait is low
    assign iload = ram[word_addr];

    // new request starts its count from zero
    assign restart = !prev_ren || (iaddr != prev_addr);
    assign cur_cnt = restart ? 8'd0 : wait_cnt;

    assign iwait = iREN && (cur_cnt != 8'(`IMEM_WAIT));

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            wait_cnt  <= '0;
            prev_ren  <= 1'b0;
            prev_addr <= '0;
        end
        else
        begin
            prev_ren  <= iREN;
            prev_addr <= iaddr;
            if (!iREN)
            begin
                wait_cnt <= '0;                 // back to idle
            end
            else if (iwait)
            begin
                wait_cnt <= cur_cnt + 8'd1;
            end
            else
            begin
                wait_cnt <= '0;                 // data delivered, count again
            end
        end
    end

endmodule

//--- hdl/fetch_subsys.sv
// instruction fetch subsystem top level
// datapath fetch port and program load port in, cache wired to the memory controller
`timescale 1ns/1ps

module fetch_subsys (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  imemREN,
    input  fetch_pkg::word_t      imemaddr,
    input  logic                  halt,
    output logic                  ihit,
    output fetch_pkg::word_t      imemload,
    input  logic                  load_en,    // program load, not during fetch
    input  fetch_pkg::imem_addr_t load_addr,
    input  fetch_pkg::word_t      load_data
);

    // cache to memory controller
    logic             iREN;
    logic             iwait;
    fetch_pkg::word_t iaddr;
    fetch_pkg::word_t iload;

    icache icache0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .imemREN  (imemREN),
        .halt     (halt),
        .iwait    (iwait),
        .iload    (iload),
        .imemaddr (imemaddr),
        .ihit     (ihit),
        .imemload (imemload),
        .iREN     (iREN),
        .iaddr    (iaddr)
    );

    imem_ctrl imem_ctrl0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .iREN      (iREN),
        .iaddr     (iaddr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .iwait     (iwait),
        .iload     (iload)
    );

endmodule

//--- verif/icache_checker.sv
// protocol assertions for the instruction cache, bound into every icache instance
// watches the fetch handshake, the memory read level and the reset values
`timescale 1ns/1ps
`include "fetch_defs.svh"

module icache_checker (
    input logic                     CLK,
    input logic                     nRST,
    input logic                     imemREN,
    input logic                     halt,
    input logic                     ihit,
    input logic                     iREN,
    input logic                     iwait,
    input fetch_pkg::icache_state_t state
);

    int   fail_cnt = 0;        // assertion failures so far
    int   ren_cnt;             // cycles iREN has already been high
    logic reset_seen = 1'b0;   // first reset applied

    always_ff @(posedge CLK)
    begin
        if (!nRST)
        begin
            reset_seen <= 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            ren_cnt <= 0;
        end
        else
        begin
            ren_cnt <= iREN ? ren_cnt + 1 : 0;
        end
    end

    // hit only for a live, unhalted request
    a_hit_req : assert property (@(posedge CLK) disable iff (!nRST)
        ihit |-> (imemREN && !halt))
    else
    begin
        $error("ihit high while halted or without imemREN");
        fail_cnt++;
    end

    a_ren_alloc : assert property (@(posedge CLK) disable iff (!nRST)
        iREN |-> (state == fetch_pkg::ALLOCATE))   // memory read only from ALLOCATE
    else
    begin
        $error("iREN high outside ALLOCATE");
        fail_cnt++;
    end

    // read level drops within IMEM_WAIT+2 cycles
    a_ren_len : assert property (@(posedge CLK) disable iff (!nRST)
        iREN |-> (ren_cnt <= `IMEM_WAIT + 1))
    else
    begin
        $error("iREN held longer than the memory wait allows");
        fail_cnt++;
    end

    a_reset_out : assert property (@(posedge CLK)
        (!nRST && reset_seen) |-> (!ihit && !iREN && !iwait))
    else
    begin
        $error("ihit, iREN or iwait high during reset");
        fail_cnt++;
    end

endmodule

bind icache icache_checker chk0 (
    .CLK     (CLK),
    .nRST    (nRST),
    .imemREN (imemREN),
    .halt    (halt),
    .ihit    (ihit),
    .iREN    (iREN),
    .iwait   (iwait),
    .state   (state)
);

//--- verif/fetch_subsys_tb.sv
// testbench for the fetch subsystem, loads random code through the load port
// and runs fetch sequences against a model of the cache tag table
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_subsys_tb;

    localparam int FETCHES   = 212;              // all tests together
    localparam int HALT_CYC  = 20;
    localparam int MAX_LAT   = `IMEM_WAIT + 3;   // request to ihit on a miss
    localparam int LIMIT_CYC = `IMEM_WORDS + 8 + FETCHES * (MAX_LAT + 1) + HALT_CYC + 200;

    logic                  CLK;
    logic                  nRST;
    logic                  imemREN;
    fetch_pkg::word_t      imemaddr;
    logic                  halt;
    logic                  ihit;
    fetch_pkg::word_t      imemload;
    logic                  load_en;
    fetch_pkg::imem_addr_t load_addr;
    fetch_pkg::word_t      load_data;

    fetch_pkg::word_t mem_copy [`IMEM_WORDS];      // expected RAM contents
    logic             mdl_valid [`ICACHE_FRAMES];  // model tag table
    fetch_pkg::tag_t  mdl_tag [`ICACHE_FRAMES];
    int               errors = 0;
    int               tests_ok = 0;
    int               tests_bad = 0;

    fetch_subsys dut0 (
        .CLK (CLK), .nRST (nRST), .imemREN (imemREN), .imemaddr (imemaddr),
        .halt (halt), .ihit (ihit), .imemload (imemload),
        .load_en (load_en), .load_addr (load_addr), .load_data (load_data)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;   // 8 ns
    end

    initial
    begin
        #(LIMIT_CYC * 8);
        $display("watchdog expired, a fetch never completed");
        $display("** FAIL **");
        $finish;
    end

    function automatic int total_errors();
        return errors + dut0.icache0.chk0.fail_cnt;   // own checks plus checker
    endfunction

    task automatic load_program();
        for (int i = 0; i < `IMEM_WORDS; i++)
        begin
            @(negedge CLK);
            load_en     = 1'b1;
            load_addr   = fetch_pkg::imem_addr_t'(i);
            load_data   = $urandom;
            mem_copy[i] = load_data;
        end
        @(negedge CLK);
        load_en = 1'b0;
    endtask

    // one fetch, held until ihit, then checked against the model
    task automatic fetch_word(input fetch_pkg::word_t addr);
        fetch_pkg::idx_t  idx;
        fetch_pkg::tag_t  tag;
        fetch_pkg::word_t exp_word;
        logic             mdl_hit;
        int               cyc;
        idx      = addr[`TAG_LSB-1:2];
        tag      = addr[31:`TAG_LSB];
        exp_word = mem_copy[addr[`IMEM_ABITS+1:2]];
        mdl_hit  = mdl_valid[idx] && (mdl_tag[idx] == tag);
        @(negedge CLK);
        imemREN  = 1'b1;
        imemaddr = addr;
        #1;                      // let the hit path settle
        cyc = 0;
        while (!ihit)
        begin
            @(negedge CLK);
            #1;
            cyc++;
        end
        assert (imemload == exp_word)
        else
        begin
            $display("[ERROR] imemload expected %h got %h (addr %h)",
                     exp_word, imemload, addr);
            errors++;
        end
        assert (mdl_hit == (cyc == 0))   // same-cycle hit exactly when resident
        else
        begin
            $display("fetch at %h was a hit or miss other than the model predicts", addr);
            errors++;
        end
        assert (cyc <= MAX_LAT && !(mdl_hit && dut0.icache0.iREN))
        else
        begin
            $display("fetch at %h took %0d cycles or read memory on a hit", addr, cyc);
            errors++;
        end
        mdl_valid[idx] = 1'b1;   // frame now holds this tag
        mdl_tag[idx]   = tag;
    endtask

    task automatic finish_test(input string name, input int base);
        if (total_errors() == base)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", name, total_errors() - base);
        end
    endtask

    initial
    begin : stimulus
        int                    base;
        fetch_pkg::imem_addr_t ra;
        void'($urandom(83152));
        nRST      = 1'b0;
        imemREN   = 1'b0;
        imemaddr  = '0;
        halt      = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        for (int i = 0; i < `ICACHE_FRAMES; i++)
        begin
            mdl_valid[i] = 1'b0;   // reset clears all frames
            mdl_tag[i]   = '0;
        end
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        load_program();

        base = total_errors();
        @(negedge CLK);
        #1;
        assert (!ihit && !dut0.icache0.iREN)
        else
        begin
            $display("[ERROR] ihit %h iREN %h after reset, expected 0",
                     ihit, dut0.icache0.iREN);
            errors++;
        end
        fetch_word(32'h0000_0000);   // model is empty, must miss
        finish_test("reset state", base);

        base = total_errors();
        fetch_word(32'h0000_0004);
        fetch_word(32'h0000_0008);
        fetch_word(32'h0000_000C);
        finish_test("cold miss", base);

        base = total_errors();
        fetch_word(32'h0000_0000);
        fetch_word(32'h0000_0008);
        fetch_word(32'h0000_0004);
        finish_test("repeated hits", base);

        // index 5, tags 9 and 12
        base = total_errors();
        repeat (2)
        begin
            fetch_word(32'h0000_0254);
            fetch_word(32'h0000_0314);
        end
        finish_test("conflict eviction", base);

        // halt first over resident 0x314, then over a missing address
        base = total_errors();
        @(negedge CLK);
        halt = 1'b1;
        for (int i = 0; i < HALT_CYC; i++)
        begin
            if (i == HALT_CYC / 2)
            begin
                imemaddr = 32'h0000_01A0;   // no fill may start either
            end
            #1;
            assert (!ihit && !dut0.icache0.iREN)
            else
            begin
                $display("[ERROR] ihit %h iREN %h while halt high, expected 0",
                         ihit, dut0.icache0.iREN);
                errors++;
            end
            @(negedge CLK);
        end
        halt = 1'b0;
        fetch_word(32'h0000_01A0);
        finish_test("halt", base);

        base = total_errors();
        repeat (200)
        begin
            ra = fetch_pkg::imem_addr_t'($urandom % `IMEM_WORDS);
            fetch_word({22'd0, ra, 2'b00});
        end
        finish_test("random sweep", base);

        @(negedge CLK);
        imemREN = 1'b0;
        repeat (2) @(negedge CLK);
        $display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, total_errors());
        if (tests_bad == 0 && total_errors() == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/imem_ctrl.sv
hdl/fetch_subsys.sv
verif/icache_checker.sv
verif/fetch_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := fetch_subsys_tb
FILELIST  := src.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps
RUNFLAGS  := +verilator+error+limit+1000
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides pass or fail
run: build
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
